// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_top -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== rv_alu.sv ====
//====================================================================
// Integer ALU and branch comparator.
// result follows alu_op; branch_taken evaluates the branch condition
// selected by funct3 on the same two operands.
//====================================================================
`timescale 1ns/100ps

module rv_alu (
    input  rv_pkg::alu_op_t          alu_op,
    input  logic [rv_pkg::xlen-1:0]  a,
    input  logic [rv_pkg::xlen-1:0]  b,
    input  logic [2:0]               funct3,
    output logic [rv_pkg::xlen-1:0]  result,
    output logic                     branch_taken
);

    logic [4:0] shamt;
    logic       lt;
    logic       ltu;

    assign shamt = b[4:0];
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = {31'b0, lt};
            rv_pkg::ALU_SLTU: result = {31'b0, ltu};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            // sign bit fills from the left
            rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            default:          result = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            rv_pkg::f3_beq:  branch_taken = (a == b);
            rv_pkg::f3_bne:  branch_taken = (a != b);
            rv_pkg::f3_blt:  branch_taken = lt;
            rv_pkg::f3_bge:  branch_taken = !lt;
            rv_pkg::f3_bltu: branch_taken = ltu;
            rv_pkg::f3_bgeu: branch_taken = !ltu;
            default:         branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== rv_control.sv ====
//====================================================================
// Core control: the C0/C1/C2/HALTED state machine, the program
// counter, ALU operand and function selection, memory requests,
// register write-back, the output port and halt.
// One instruction in flight; every wait ends on mem_rsp.ack.
//====================================================================
`timescale 1ns/100ps

module rv_control (
    input  logic                              clk,
    input  logic                              rst,
    input  rv_pkg::decoded_t                  dec,
    input  logic [rv_pkg::xlen-1:0]           rs1_data,
    input  logic [rv_pkg::xlen-1:0]           rs2_data,
    input  logic [rv_pkg::xlen-1:0]           alu_result,
    input  logic                              branch_taken,
    output rv_pkg::alu_op_t                   alu_op,
    output logic [rv_pkg::xlen-1:0]           alu_a,
    output logic [rv_pkg::xlen-1:0]           alu_b,
    output logic                              wr_en,
    output logic [rv_pkg::reg_sel_width-1:0]  wr_sel,
    output logic [rv_pkg::xlen-1:0]           wr_data,
    output rv_pkg::mem_req_t                  mem_req,
    input  rv_pkg::mem_rsp_t                  mem_rsp,
    output logic [rv_pkg::xlen-1:0]           out_data,
    output logic                              out_valid,
    output logic                              halt
);

    typedef enum logic [1:0] {
        C0,
        C1,
        C2,
        HALTED
    } state_t;

    state_t                           state;
    state_t                           next_state;
    logic [rv_pkg::xlen-1:0]          pc;
    logic [rv_pkg::xlen-1:0]          next_pc;
    logic [rv_pkg::reg_sel_width-1:0] load_rd;
    logic [rv_pkg::reg_sel_width-1:0] next_load_rd;

    rv_pkg::alu_op_t         f3_op;
    logic                    fetch;
    logic [rv_pkg::xlen-1:0] target;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [rv_pkg::xlen-1:0] pc_rel;
    logic [rv_pkg::xlen-1:0] jalr_sum;

    assign pc_plus4 = pc + 32'd4;
    assign pc_rel   = pc + dec.imm;
    assign jalr_sum = rs1_data + dec.imm;
    assign out_data = rs2_data;
    assign halt     = (state == HALTED);

    // funct3 to ALU function; the alternate encoding only means SUB for OP
    always_comb begin
        case (dec.funct3)
            rv_pkg::f3_add: begin
                f3_op = (dec.alt && dec.op == rv_pkg::OP) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            end
            rv_pkg::f3_sll:  f3_op = rv_pkg::ALU_SLL;
            rv_pkg::f3_slt:  f3_op = rv_pkg::ALU_SLT;
            rv_pkg::f3_sltu: f3_op = rv_pkg::ALU_SLTU;
            rv_pkg::f3_xor:  f3_op = rv_pkg::ALU_XOR;
            rv_pkg::f3_srl:  f3_op = dec.alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::f3_or:   f3_op = rv_pkg::ALU_OR;
            default:         f3_op = rv_pkg::ALU_AND;
        endcase
    end

    // operand choice; loads and stores use the adder for their address
    always_comb begin
        alu_a  = rs1_data;
        alu_b  = dec.imm;
        alu_op = rv_pkg::ALU_ADD;
        case (dec.op)
            rv_pkg::OP: begin
                alu_b  = rs2_data;
                alu_op = f3_op;
            end
            rv_pkg::OPIMM:  alu_op = f3_op;
            rv_pkg::LUI:    alu_a = '0;
            rv_pkg::AUIPC:  alu_a = pc;
            rv_pkg::BRANCH: alu_b = rs2_data;
            rv_pkg::JAL, rv_pkg::JALR: begin
                // link value pc + 4
                alu_a = pc;
                alu_b = 32'd4;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        next_state    = state;
        next_pc       = pc;
        next_load_rd  = load_rd;
        mem_req       = '0;
        mem_req.wdata = rs2_data;
        wr_en         = 1'b0;
        wr_sel        = dec.rd;
        wr_data       = alu_result;
        out_valid     = 1'b0;
        fetch         = 1'b0;
        target        = pc_plus4;

        case (state)
            C0: begin
                fetch  = 1'b1;
                target = pc;
            end
            C1: begin
                if (mem_rsp.ack) begin
                    case (dec.op)
                        rv_pkg::OP, rv_pkg::OPIMM, rv_pkg::LUI, rv_pkg::AUIPC: begin
                            wr_en = 1'b1;
                            fetch = 1'b1;
                        end
                        rv_pkg::JAL: begin
                            wr_en  = 1'b1;
                            fetch  = 1'b1;
                            target = pc_rel;
                        end
                        rv_pkg::JALR: begin
                            wr_en  = 1'b1;
                            fetch  = 1'b1;
                            target = {jalr_sum[rv_pkg::xlen-1:1], 1'b0};
                        end
                        rv_pkg::BRANCH: begin
                            fetch  = 1'b1;
                            target = branch_taken ? pc_rel : pc_plus4;
                        end
                        rv_pkg::LOAD: begin
                            mem_req.rd   = 1'b1;
                            mem_req.addr = alu_result;
                            next_load_rd = dec.rd;
                            next_state   = C2;
                        end
                        rv_pkg::STORE: begin
                            if (alu_result == rv_pkg::out_addr) begin
                                out_valid = 1'b1;
                                fetch     = 1'b1;
                            end else if (alu_result == rv_pkg::halt_addr) begin
                                next_state = HALTED;
                            end else begin
                                mem_req.wr   = 1'b1;
                                mem_req.addr = alu_result;
                                // x0 as target, so the write ack changes no register
                                next_load_rd = '0;
                                next_state   = C2;
                            end
                        end
                        default: next_state = HALTED;
                    endcase
                end
            end
            C2: begin
                if (mem_rsp.ack) begin
                    wr_en   = 1'b1;
                    wr_sel  = load_rd;
                    wr_data = mem_rsp.rdata;
                    fetch   = 1'b1;
                end
            end
            default: begin
            end
        endcase

        if (fetch) begin
            mem_req.rd   = 1'b1;
            mem_req.addr = target;
            next_pc      = target;
            next_state   = C1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= C0;
            pc      <= '0;
            load_rd <= '0;
        end else begin
            state   <= next_state;
            pc      <= next_pc;
            load_rd <= next_load_rd;
        end
    end

endmodule

// ==== rv_core.sv ====
//====================================================================
// Top level of the multi-cycle RV32I core. Connects decoder,
// register file, ALU and control to one request/ack memory port,
// the memory-mapped output port and the halt flag.
//====================================================================
`timescale 1ns/100ps

module rv_core (
    input  logic                     clk,
    input  logic                     rst,
    output rv_pkg::mem_req_t         mem_req,
    input  rv_pkg::mem_rsp_t         mem_rsp,
    output logic [rv_pkg::xlen-1:0]  out_data,
    output logic                     out_valid,
    output logic                     halt
);

    rv_pkg::decoded_t                 dec;
    rv_pkg::alu_op_t                  alu_op;
    logic [rv_pkg::xlen-1:0]          rs1_data;
    logic [rv_pkg::xlen-1:0]          rs2_data;
    logic [rv_pkg::xlen-1:0]          alu_a;
    logic [rv_pkg::xlen-1:0]          alu_b;
    logic [rv_pkg::xlen-1:0]          alu_result;
    logic                             branch_taken;
    logic                             wr_en;
    logic [rv_pkg::reg_sel_width-1:0] wr_sel;
    logic [rv_pkg::xlen-1:0]          wr_data;

    // decode runs on read data; only meaningful in a fetch ack cycle
    rv_decode u_decode (
        .instr (mem_rsp.rdata),
        .dec   (dec)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (dec.rs1),
        .rs2_sel  (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

    rv_alu u_alu (
        .alu_op       (alu_op),
        .a            (alu_a),
        .b            (alu_b),
        .funct3       (dec.funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv_control u_control (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .wr_data      (wr_data),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .halt         (halt)
    );

endmodule

// ==== rv_decode.sv ====
//====================================================================
// Instruction decoder. Splits a fetched word into register selects,
// function fields and the sign-extended immediate of its format.
// Purely combinational; fed straight from the memory read data.
//====================================================================
`timescale 1ns/100ps

module rv_decode (
    input  logic [rv_pkg::xlen-1:0] instr,
    output rv_pkg::decoded_t        dec
);

    rv_pkg::instr_u iw;
    rv_pkg::op_t    op;

    assign iw = instr;
    assign op = rv_pkg::op_t'({1'b0, iw.r_fmt.opcode});

    always_comb begin
        dec.op     = op;
        dec.rd     = iw.r_fmt.rd;
        dec.rs1    = iw.r_fmt.rs1;
        dec.rs2    = iw.r_fmt.rs2;
        dec.funct3 = iw.r_fmt.funct3;
        // also set for SRAI, whose upper immediate bits match
        dec.alt    = (iw.r_fmt.funct7 == rv_pkg::funct7_alt);

        case (op)
            rv_pkg::OPIMM, rv_pkg::LOAD, rv_pkg::JALR: begin
                dec.imm = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
            end
            rv_pkg::STORE: begin
                dec.imm = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
            end
            rv_pkg::BRANCH: begin
                dec.imm = {{20{iw.b_fmt.imm_12}}, iw.b_fmt.imm_11,
                           iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
            end
            rv_pkg::LUI, rv_pkg::AUIPC: begin
                dec.imm = {iw.u_fmt.imm, 12'b0};
            end
            rv_pkg::JAL: begin
                dec.imm = {{12{iw.j_fmt.imm_20}}, iw.j_fmt.imm_19_12,
                           iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};
            end
            default: begin
                // R format and unknown opcodes carry no immediate
                dec.imm = '0;
            end
        endcase
    end

endmodule

// ==== rv_pkg.sv ====
//====================================================================
// Shared definitions for the rv_core RV32I integer core: widths,
// opcodes, function codes, memory-mapped addresses, the instruction
// format views and the memory port structs.
// Every design and testbench file refers to these by rv_pkg:: names.
//====================================================================
package rv_pkg;

    localparam int xlen          = 32;
    localparam int reg_sel_width = 5;

    // major opcodes, widened to one byte
    typedef enum logic [7:0] {
        LOAD   = 8'h03,
        OPIMM  = 8'h13,
        AUIPC  = 8'h17,
        STORE  = 8'h23,
        OP     = 8'h33,
        LUI    = 8'h37,
        BRANCH = 8'h63,
        JALR   = 8'h67,
        JAL    = 8'h6f
    } op_t;

    // funct3 for OP and OPIMM
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // selects SUB and SRA/SRAI
    localparam logic [6:0] funct7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // stores to these addresses are actions, not memory writes
    localparam logic [xlen-1:0] out_addr  = 32'd1000;
    localparam logic [xlen-1:0] halt_addr = 32'd1004;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, seen through each encoding
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        op_t                      op;
        logic [reg_sel_width-1:0] rd;
        logic [reg_sel_width-1:0] rs1;
        logic [reg_sel_width-1:0] rs2;
        logic [2:0]               funct3;
        logic                     alt;
        logic [xlen-1:0]          imm;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            rd;
        logic            wr;
    } mem_req_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            ack;
    } mem_rsp_t;

endpackage

// ==== rv_regfile.sv ====
//====================================================================
// Integer register file: x1..x31 in flops, x0 reads as zero.
// Two combinational read ports, one write port on the clock edge.
//====================================================================
`timescale 1ns/100ps

module rv_regfile (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [rv_pkg::reg_sel_width-1:0]  rs1_sel,
    input  logic [rv_pkg::reg_sel_width-1:0]  rs2_sel,
    output logic [rv_pkg::xlen-1:0]           rs1_data,
    output logic [rv_pkg::xlen-1:0]           rs2_data,
    input  logic                              wr_en,
    input  logic [rv_pkg::reg_sel_width-1:0]  wr_sel,
    input  logic [rv_pkg::xlen-1:0]           wr_data
);

    logic [rv_pkg::xlen-1:0] regs [1:31];

    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            // writes to x0 are dropped
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

// ==== tb.f ====
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_control.sv
rv_core.sv
tb_clock.sv
tb_mem.sv
tb_top_assert.sv
tb_top.sv

// ==== tb_clock.sv ====
//======================================================================
// Testbench clock and reset source. clk has a 100 ns period.
// rst is high for 16 cycles at start and after each restart pulse.
//======================================================================
`timescale 1ns/100ps

module tb_clock (
    input  logic restart,
    output logic clk,
    output logic rst
);

    logic [4:0] rst_cnt = 5'd16;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    assign rst = (rst_cnt != 5'd0);

    always @(posedge clk) begin
        if (restart) begin
            rst_cnt <= 5'd16;
        end else if (rst_cnt != 5'd0) begin
            rst_cnt <= rst_cnt - 5'd1;
        end
    end

endmodule

// ==== tb_mem.sv ====
//======================================================================
// Testbench memory with the core's request/ack handshake.
// Each request is acknowledged 1 to 4 cycles later, the delay drawn
// from $random. The last data write is kept for the testbench.
//======================================================================
`timescale 1ns/100ps

module tb_mem (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::mem_req_t mem_req,
    output rv_pkg::mem_rsp_t mem_rsp
);

    logic [31:0] words [0:511];
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;
    logic        busy;
    logic        pend_wr;
    logic [1:0]  wait_cnt;
    logic [31:0] pend_addr;
    logic [31:0] pend_wdata;
    logic [31:0] rnd;
    integer      seed = 41;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            pend_wr      <= 1'b0;
            wait_cnt     <= 2'd0;
            pend_addr    <= 32'd0;
            pend_wdata   <= 32'd0;
            mem_rsp      <= '0;
            last_wr_addr <= 32'd0;
            last_wr_data <= 32'd0;
        end else begin
            mem_rsp.ack <= 1'b0;
            if (busy) begin
                if (wait_cnt == 2'd0) begin
                    busy          <= 1'b0;
                    mem_rsp.ack   <= 1'b1;
                    mem_rsp.rdata <= words[pend_addr[10:2]];
                    if (pend_wr) begin
                        words[pend_addr[10:2]] = pend_wdata;
                        last_wr_addr <= pend_addr;
                        last_wr_data <= pend_wdata;
                    end
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (mem_req.rd || mem_req.wr) begin
                // remaining wait of 0..3 gives an ack 1..4 cycles later
                rnd = $random(seed);
                busy       <= 1'b1;
                wait_cnt   <= rnd[1:0];
                pend_wr    <= mem_req.wr;
                pend_addr  <= mem_req.addr;
                pend_wdata <= mem_req.wdata;
            end
        end
    end

endmodule

// ==== tb_top.sv ====
//======================================================================
// Testbench for rv_core. Each table row builds a short program in
// tb_mem, restarts the core, collects the words it writes to the
// output port and compares them with the RISC-V result of the row.
//======================================================================
`timescale 1ns/100ps

module tb_top;

    localparam int num_rows = 25;

    // row operations
    typedef enum logic [4:0] {
        t_add, t_sub, t_and, t_or, t_xor,
        t_sll, t_srl, t_sra, t_slt, t_sltu,
        t_addi, t_sltiu, t_srai, t_xori, t_lui, t_auipc,
        t_ldst, t_beq, t_bne, t_blt, t_bge, t_bltu, t_bgeu,
        t_jal, t_badop
    } row_op_t;

    typedef struct packed {
        row_op_t     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expect_word;
        logic        has_out;
    } row_t;

    row_t                rows [num_rows];
    logic                clk;
    logic                rst;
    logic                restart;
    rv_pkg::mem_req_t    mem_req;
    rv_pkg::mem_rsp_t    mem_rsp;
    logic [31:0]         out_data;
    logic                out_valid;
    logic                halt;

    tb_clock clock_gen (.restart(restart), .clk(clk), .rst(rst));
    tb_mem   mem_model (.clk(clk), .rst(rst), .mem_req(mem_req), .mem_rsp(mem_rsp));

    rv_core DUT (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halt      (halt)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic add_row(input int idx, input row_op_t op, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] exp);
        rows[idx] = '{op, a, b, exp, (op != t_badop)};
    endtask

    task automatic fill_table();
        add_row(0,  t_add,   32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
        add_row(1,  t_sub,   32'h0000_0005, 32'h0000_0007, 32'hffff_fffe);
        add_row(2,  t_and,   32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200);
        add_row(3,  t_or,    32'hf000_000f, 32'h0f00_00f0, 32'hff00_00ff);
        add_row(4,  t_xor,   32'haaaa_5555, 32'hffff_0000, 32'h5555_5555);
        // only the low five bits of the shift amount count
        add_row(5,  t_sll,   32'h0000_0003, 32'h0000_0024, 32'h0000_0030);
        add_row(6,  t_srl,   32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
        add_row(7,  t_sra,   32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
        add_row(8,  t_slt,   32'hffff_fffe, 32'h0000_0001, 32'h0000_0001);
        add_row(9,  t_sltu,  32'hffff_fffe, 32'h0000_0001, 32'h0000_0000);
        add_row(10, t_addi,  32'h0000_000a, 32'h0000_0800, 32'hffff_f80a);
        add_row(11, t_sltiu, 32'h0000_0005, 32'h0000_0fff, 32'h0000_0001);
        add_row(12, t_srai,  32'hf000_0000, 32'h0000_0408, 32'hfff0_0000);
        add_row(13, t_xori,  32'h1234_5678, 32'h0000_0fff, 32'hedcb_a987);
        add_row(14, t_lui,   32'h0000_0000, 32'h000a_bcde, 32'habcd_e000);
        // AUIPC sits at pc 16
        add_row(15, t_auipc, 32'h0000_0000, 32'h0000_0001, 32'h0000_1010);
        add_row(16, t_ldst,  32'hcafe_babe, 32'h0000_0000, 32'hcafe_babe);
        // branch rows give 1 when taken and 2 when not
        add_row(17, t_beq,   32'h0000_0005, 32'h0000_0005, 32'h0000_0001);
        add_row(18, t_bne,   32'h0000_0005, 32'h0000_0005, 32'h0000_0002);
        add_row(19, t_blt,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
        add_row(20, t_bge,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0002);
        add_row(21, t_bltu,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0002);
        add_row(22, t_bgeu,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
        // link of a JAL at pc 16
        add_row(23, t_jal,   32'h0000_0000, 32'h0000_0000, 32'h0000_0014);
        add_row(24, t_badop, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000);
    endtask

    task automatic set_reg(input int idx, input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        mem_model.words[idx] = {hi[31:12], rd, 7'h37};
        mem_model.words[idx + 1] = enc_i(v[11:0], rd, 3'b000, rd, 7'h13);
    endtask

    // store x3 to the output port, then halt
    task automatic put_tail(input int idx);
        mem_model.words[idx] = enc_s(12'd1000, 5'd3);
        mem_model.words[idx + 1] = enc_s(12'd1004, 5'd0);
    endtask

    task automatic load_program(input row_t r);
        logic [2:0] bf3;
        // spare words carry their own index and an illegal opcode
        for (int i = 0; i < 512; i++) begin
            mem_model.words[i] = {i[15:0], 16'hdead};
        end
        set_reg(0, 5'd1, r.a);
        set_reg(2, 5'd2, r.b);
        bf3 = 3'b000;
        case (r.op)
            t_add:   mem_model.words[4] = enc_r(7'h00, 3'b000);
            t_sub:   mem_model.words[4] = enc_r(7'h20, 3'b000);
            t_and:   mem_model.words[4] = enc_r(7'h00, 3'b111);
            t_or:    mem_model.words[4] = enc_r(7'h00, 3'b110);
            t_xor:   mem_model.words[4] = enc_r(7'h00, 3'b100);
            t_sll:   mem_model.words[4] = enc_r(7'h00, 3'b001);
            t_srl:   mem_model.words[4] = enc_r(7'h00, 3'b101);
            t_sra:   mem_model.words[4] = enc_r(7'h20, 3'b101);
            t_slt:   mem_model.words[4] = enc_r(7'h00, 3'b010);
            t_sltu:  mem_model.words[4] = enc_r(7'h00, 3'b011);
            t_addi:  mem_model.words[4] = enc_i(r.b[11:0], 5'd1, 3'b000, 5'd3, 7'h13);
            t_sltiu: mem_model.words[4] = enc_i(r.b[11:0], 5'd1, 3'b011, 5'd3, 7'h13);
            t_srai:  mem_model.words[4] = enc_i(r.b[11:0], 5'd1, 3'b101, 5'd3, 7'h13);
            t_xori:  mem_model.words[4] = enc_i(r.b[11:0], 5'd1, 3'b100, 5'd3, 7'h13);
            t_lui:   mem_model.words[4] = {r.b[19:0], 5'd3, 7'h37};
            t_auipc: mem_model.words[4] = {r.b[19:0], 5'd3, 7'h17};
            t_jal: begin
                mem_model.words[4] = enc_j(21'd8, 5'd3);
                mem_model.words[5] = enc_i(12'd2, 5'd0, 3'b000, 5'd3, 7'h13);
            end
            t_badop: mem_model.words[4] = 32'hffff_ffff;
            default: begin
            end
        endcase
        case (r.op)
            t_beq:  bf3 = 3'b000;
            t_bne:  bf3 = 3'b001;
            t_blt:  bf3 = 3'b100;
            t_bge:  bf3 = 3'b101;
            t_bltu: bf3 = 3'b110;
            t_bgeu: bf3 = 3'b111;
            default: begin
            end
        endcase
        if (r.op == t_ldst) begin
            mem_model.words[4] = enc_s(12'h200, 5'd1);
            mem_model.words[5] = enc_i(12'h200, 5'd0, 3'b010, 5'd3, 7'h03);
            put_tail(6);
        end else if (r.op >= t_beq && r.op <= t_bgeu) begin
            mem_model.words[4] = enc_i(12'd1, 5'd0, 3'b000, 5'd3, 7'h13);
            mem_model.words[5] = enc_b(13'd8, bf3);
            mem_model.words[6] = enc_i(12'd2, 5'd0, 3'b000, 5'd3, 7'h13);
            put_tail(7);
        end else if (r.op == t_jal) begin
            put_tail(6);
        end else begin
            put_tail(5);
        end
    endtask

    task automatic run_row(input row_t r);
        int n_out;
        n_out = 0;
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        while (!rst) @(posedge clk);
        load_program(r);
        while (rst) @(negedge clk);
        // first cycle out of reset
        check("halt", {31'b0, halt}, 32'h0);
        check("out_valid", {31'b0, out_valid}, 32'h0);
        check("mem_req.rd", {31'b0, mem_req.rd}, 32'h1);
        check("mem_req.wr", {31'b0, mem_req.wr}, 32'h0);
        check("mem_req.addr", mem_req.addr, 32'h0);
        while (!halt) begin
            @(negedge clk);
            if (out_valid) begin
                check("out_data", out_data, r.expect_word);
                n_out++;
            end
        end
        check("output count", n_out, {31'b0, r.has_out});
        if (r.op == t_ldst) begin
            check("mem write addr", mem_model.last_wr_addr, 32'h200);
            check("mem write data", mem_model.last_wr_data, r.a);
        end
    endtask

    initial begin
        restart = 1'b0;
        fill_table();
        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // watchdog sized for every row at the slowest memory latency
    initial begin
        repeat (num_rows * 40 * 4) @(posedge clk);
        $display("timeout: the core stopped making progress");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

// ==== tb_top_assert.sv ====
//======================================================================
// Concurrent checks on the core's memory port and halt flag.
// Bound into every rv_core instance.
//======================================================================
`timescale 1ns/100ps

module tb_top_assert (
    input logic             clk,
    input logic             rst,
    input rv_pkg::mem_req_t mem_req,
    input rv_pkg::mem_rsp_t mem_rsp,
    input logic             halt
);

    // a request is open from its issue until its ack
    logic pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (mem_req.rd || mem_req.wr) begin
            pending <= 1'b1;
        end else if (mem_rsp.ack) begin
            pending <= 1'b0;
        end
    end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd && mem_req.wr))
        else $error("memory read and write requested in the same cycle");

    quiet_when_halted: assert property (@(posedge clk) disable iff (rst)
        halt |-> !(mem_req.rd || mem_req.wr))
        else $error("memory request issued while halted");

    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        (mem_req.rd || mem_req.wr) |-> (!pending || mem_rsp.ack))
        else $error("new memory request before the previous ack");

endmodule

bind rv_core tb_top_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .halt    (halt)
);
